// File: decode_stage.f
logic/decode_pkg.sv
logic/fetch_queue.sv
logic/imm_gen.sv
logic/instr_decode.sv
logic/issue_buffer.sv
logic/decode_stage.sv
+incdir+sim
sim/decode_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= decode_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: sim/decode_tasks.svh
`ifndef DECODE_TASKS_SVH
`define DECODE_TASKS_SVH

// x[r] holds r * 0x01010101
function automatic word_t reg_val(input reg_addr_t r);
    return {27'h0, r} * 32'h0101_0101;
endfunction

function automatic reg_addr_t rand_reg();
    integer r;
    r = $random(seed);
    return r[4:0];
endfunction

// random value in the signed range of a bits-wide field
function automatic word_t rand_imm(input int bits, input bit neg);
    word_t v;
    v = $random(seed);
    if (neg || v[bits-1]) begin
        v = v | (32'hffff_ffff << (bits - 1));
    end else begin
        v = v & ~(32'hffff_ffff << (bits - 1));
    end
    return v;
endfunction

function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
endfunction

function automatic word_t enc_i(input word_t imm, input logic [2:0] f3, input reg_addr_t rd,
                                input reg_addr_t rs1, input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic word_t enc_s(input word_t imm, input logic [2:0] f3,
                                input reg_addr_t rs1, input reg_addr_t rs2);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
endfunction

function automatic word_t enc_b(input word_t imm, input logic [2:0] f3,
                                input reg_addr_t rs1, input reg_addr_t rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPCODE_BRANCH};
endfunction

function automatic word_t enc_j(input word_t imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPCODE_JAL};
endfunction

function automatic word_t enc_u(input word_t imm, input reg_addr_t rd, input logic [6:0] opc);
    return {imm[31:12], rd, opc};
endfunction

// fields every instruction carries
function automatic issue_pkt_t base_pkt(input word_t pc, input word_t instr);
    issue_pkt_t p;
    p          = '0;
    p.alu_op   = ALU_NONE;
    p.lsu_op   = LSU_NONE;
    p.jump_op  = JUMP_NONE;
    p.pc       = pc;
    p.rd_addr  = instr[11:7];
    p.rs1_data = reg_val(instr[19:15]);
    p.rs2_data = reg_val(instr[24:20]);
    return p;
endfunction

function automatic issue_pkt_t reg_op_pkt(input word_t pc, input word_t instr,
                                          input alu_op_e op);
    issue_pkt_t p;
    p         = base_pkt(pc, instr);
    p.alu_a   = reg_val(instr[19:15]);
    p.alu_b   = reg_val(instr[24:20]);
    p.alu_op  = op;
    p.alu_sel = (op != ALU_NONE);
    p.rd_we   = (op != ALU_NONE);
    return p;
endfunction

// jal and jalr write pc + 4 to rd
function automatic issue_pkt_t link_pkt(input word_t pc, input word_t instr,
                                        input jump_op_e op, input word_t imm);
    issue_pkt_t p;
    p          = base_pkt(pc, instr);
    p.alu_a    = pc;
    p.alu_b    = 32'd4;
    p.alu_op   = ALU_ADD;
    p.alu_sel  = 1'b1;
    p.rd_we    = 1'b1;
    p.jump_op  = op;
    p.jump_imm = imm;
    return p;
endfunction

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "decode stage testbench stopped on error");
endtask

task automatic check_pkt(input string name, input issue_pkt_t exp, input issue_pkt_t act);
    if (act !== exp) begin
        fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        fail_run($sformatf("Mismatch in %s: expected %0d, actual %0d", name, exp, act));
    end
endtask

// waits for a fetch credit, then drives one instruction for one cycle
task automatic send_instr(input word_t pc, input word_t instr);
    int waited;
    waited = 0;
    while (sent_cnt - credit_pulses >= QUEUE_DEPTH) begin
        if (waited == TIMEOUT) begin
            fail_run("no fetch credit came back from the decode stage");
        end
        @(posedge clk);
        #1;
        waited++;
    end
    fetch_valid     = 1'b1;
    fetch_pkt.pc    = pc;
    fetch_pkt.instr = instr;
    sent_cnt++;
    send_cycle = cycle;
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
endtask

task automatic wait_issue(input string name, output issue_pkt_t act, output int cyc);
    int waited;
    waited = 0;
    while (issued_q.size() == 0) begin
        if (waited == TIMEOUT) begin
            fail_run($sformatf("%s: no packet was issued", name));
        end
        @(posedge clk);
        #1;
        waited++;
    end
    act = issued_q.pop_front();
    cyc = issue_cycle_q.pop_front();
endtask

task automatic run_one(input string name, input word_t instr, input issue_pkt_t exp);
    issue_pkt_t act;
    int         cyc;
    send_instr(exp.pc, instr);
    wait_issue(name, act, cyc);
    check_pkt(name, exp, act);
    next_pc = next_pc + 32'd4;
endtask

task automatic test_reset();
    word_t      instr;
    issue_pkt_t exp;
    issue_pkt_t act;
    int         cyc;
    repeat (5) @(posedge clk);
    #1;
    check_count("idle issue count", 0, issued_cnt);
    check_count("idle fetch credits", 0, credit_pulses);
    instr       = enc_i(32'h0000_0123, 3'h0, 5'd3, 5'd7, OPCODE_OP_IMM);
    exp         = base_pkt(next_pc, instr);
    exp.alu_a   = reg_val(5'd7);
    exp.alu_b   = 32'h0000_0123;
    exp.alu_op  = ALU_ADD;
    exp.alu_sel = 1'b1;
    exp.rd_we   = 1'b1;
    send_instr(next_pc, instr);
    wait_issue("first issue", act, cyc);
    check_pkt("first issue", exp, act);
    check_count("first issue latency", send_cycle + 2, cyc);
    next_pc = next_pc + 32'd4;
endtask

task automatic op_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                       input alu_op_e op);
    word_t instr;
    instr = enc_r(f7, f3, rand_reg(), rand_reg(), rand_reg());
    run_one(name, instr, reg_op_pkt(next_pc, instr, op));
endtask

// shifts carry funct7 and shamt in the immediate field
task automatic imm_op_case(input string name, input logic [2:0] f3, input logic [6:0] hi7,
                           input bit is_shift, input alu_op_e op);
    word_t      instr;
    word_t      imm;
    logic [4:0] shamt;
    issue_pkt_t exp;
    shamt = rand_reg();
    imm   = is_shift ? {20'h0, hi7, shamt} : rand_imm(12, 1'b0);
    instr = enc_i(imm, f3, rand_reg(), rand_reg(), OPCODE_OP_IMM);
    exp         = base_pkt(next_pc, instr);
    exp.alu_a   = reg_val(instr[19:15]);
    exp.alu_b   = is_shift ? {27'h0, shamt} : imm;
    exp.alu_op  = op;
    exp.alu_sel = 1'b1;
    exp.rd_we   = 1'b1;
    run_one(name, instr, exp);
endtask

task automatic test_alu();
    op_case("add", 7'h00, 3'h0, ALU_ADD);
    op_case("sub", 7'h20, 3'h0, ALU_SUB);
    op_case("xor", 7'h00, 3'h4, ALU_XOR);
    op_case("or", 7'h00, 3'h6, ALU_OR);
    op_case("and", 7'h00, 3'h7, ALU_AND);
    op_case("sll", 7'h00, 3'h1, ALU_SLL);
    op_case("srl", 7'h00, 3'h5, ALU_SRL);
    op_case("sra", 7'h20, 3'h5, ALU_SRA);
    op_case("slt", 7'h00, 3'h2, ALU_SLT);
    op_case("sltu", 7'h00, 3'h3, ALU_SLTU);
    op_case("op bad funct7", 7'h01, 3'h0, ALU_NONE);
    imm_op_case("addi", 3'h0, 7'h00, 1'b0, ALU_ADD);
    imm_op_case("xori", 3'h4, 7'h00, 1'b0, ALU_XOR);
    imm_op_case("ori", 3'h6, 7'h00, 1'b0, ALU_OR);
    imm_op_case("andi", 3'h7, 7'h00, 1'b0, ALU_AND);
    imm_op_case("slti", 3'h2, 7'h00, 1'b0, ALU_SLT);
    imm_op_case("sltiu", 3'h3, 7'h00, 1'b0, ALU_SLTU);
    imm_op_case("slli", 3'h1, 7'h00, 1'b1, ALU_SLL);
    imm_op_case("srli", 3'h5, 7'h00, 1'b1, ALU_SRL);
    imm_op_case("srai", 3'h5, 7'h20, 1'b1, ALU_SRA);
endtask

task automatic mem_case(input string name, input bit is_store, input logic [2:0] f3,
                        input lsu_op_e op);
    word_t      instr;
    word_t      imm;
    issue_pkt_t exp;
    imm = rand_imm(12, 1'b0);
    if (is_store) begin
        instr = enc_s(imm, f3, rand_reg(), rand_reg());
    end else begin
        instr = enc_i(imm, f3, rand_reg(), rand_reg(), OPCODE_LOAD);
    end
    exp         = base_pkt(next_pc, instr);
    exp.alu_a   = reg_val(instr[19:15]);   // address base
    exp.alu_b   = imm;
    exp.lsu_req = 1'b1;
    exp.lsu_we  = is_store;
    exp.rd_we   = !is_store;
    exp.lsu_op  = op;
    run_one(name, instr, exp);
endtask

task automatic test_mem();
    mem_case("lb", 1'b0, 3'h0, LSU_LB);
    mem_case("lh", 1'b0, 3'h1, LSU_LH);
    mem_case("lw", 1'b0, 3'h2, LSU_LW);
    mem_case("lbu", 1'b0, 3'h4, LSU_LBU);
    mem_case("lhu", 1'b0, 3'h5, LSU_LHU);
    mem_case("sb", 1'b1, 3'h0, LSU_SB);
    mem_case("sh", 1'b1, 3'h1, LSU_SH);
    mem_case("sw", 1'b1, 3'h2, LSU_SW);
endtask

task automatic branch_case(input string name, input logic [2:0] f3, input jump_op_e op);
    word_t      instr;
    word_t      imm;
    issue_pkt_t exp;
    imm   = rand_imm(13, 1'b1) & ~32'h1;   // backward branch
    instr = enc_b(imm, f3, rand_reg(), rand_reg());
    exp           = base_pkt(next_pc, instr);
    exp.alu_a     = next_pc;
    exp.alu_b     = imm;
    exp.cond_jump = 1'b1;
    exp.jump_op   = op;
    run_one(name, instr, exp);
endtask

task automatic upper_case(input string name, input opcode_e opc);
    word_t      instr;
    word_t      imm;
    issue_pkt_t exp;
    imm   = rand_imm(32, 1'b1) & 32'hffff_f000;
    instr = enc_u(imm, rand_reg(), opc);
    exp         = base_pkt(next_pc, instr);
    exp.alu_a   = (opc == OPCODE_AUIPC) ? next_pc : 32'h0;
    exp.alu_b   = imm;
    exp.alu_op  = ALU_ADD;
    exp.alu_sel = 1'b1;
    exp.rd_we   = 1'b1;
    run_one(name, instr, exp);
endtask

task automatic test_ctrl();
    word_t instr;
    word_t imm;
    branch_case("beq", 3'h0, JUMP_BEQ);
    branch_case("bne", 3'h1, JUMP_BNE);
    branch_case("blt", 3'h4, JUMP_BLT);
    branch_case("bge", 3'h5, JUMP_BGE);
    branch_case("bltu", 3'h6, JUMP_BLTU);
    branch_case("bgeu", 3'h7, JUMP_BGEU);
    imm   = rand_imm(21, 1'b1) & ~32'h1;
    instr = enc_j(imm, rand_reg());
    run_one("jal", instr, link_pkt(next_pc, instr, JUMP_JAL, imm));
    imm   = rand_imm(12, 1'b1);
    instr = enc_i(imm, 3'h0, rand_reg(), rand_reg(), OPCODE_JALR);
    run_one("jalr", instr, link_pkt(next_pc, instr, JUMP_JALR, imm));
    upper_case("lui", OPCODE_LUI);
    upper_case("auipc", OPCODE_AUIPC);
endtask

task automatic test_backpressure();
    issue_pkt_t exp_q[$];
    issue_pkt_t act;
    word_t      instr;
    int         cyc;
    int         waited;
    int         base_issued;
    int         base_pulses;
    waited = 0;
    while (returned_cnt != issued_cnt || sent_cnt != credit_pulses) begin
        if (waited == TIMEOUT) begin
            fail_run("credits did not settle before the back-pressure test");
        end
        @(posedge clk);
        #1;
        waited++;
    end
    hold_credits = 1'b1;
    base_issued  = issued_cnt;
    base_pulses  = credit_pulses;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        instr = enc_r(7'h00, 3'h0, rand_reg(), rand_reg(), rand_reg());
        exp_q.push_back(reg_op_pkt(next_pc, instr, ALU_ADD));
        send_instr(next_pc, instr);
        next_pc = next_pc + 32'd4;
    end
    repeat (10) @(posedge clk);
    #1;
    check_count("issued while starved", EXEC_CREDITS, issued_cnt - base_issued);
    hold_credits = 1'b0;
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
        wait_issue("back-pressure drain", act, cyc);
        check_pkt($sformatf("back-pressure packet %0d", i), exp_q[i], act);
    end
    waited = 0;
    while (credit_pulses - base_pulses < QUEUE_DEPTH) begin
        if (waited == TIMEOUT) begin
            fail_run("fetch credits missing after back-pressure drain");
        end
        @(posedge clk);
        #1;
        waited++;
    end
    repeat (5) @(posedge clk);
    #1;
    check_count("back-pressure fetch credits", QUEUE_DEPTH, credit_pulses - base_pulses);
    check_count("back-pressure issue count", QUEUE_DEPTH, issued_cnt - base_issued);
endtask

`endif

// File: sim/decode_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage_tb;
    import decode_pkg::*;

    localparam int QUEUE_DEPTH  = 4;
    localparam int EXEC_CREDITS = 2;
    localparam int TIMEOUT      = 40;   // cycles per wait loop

    logic       clk           = 1'b0;
    logic       rst_n;
    logic       fetch_valid;
    fetch_pkt_t fetch_pkt;
    logic       fetch_credit;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rs1_rdata;
    word_t      rs2_rdata;
    logic       issue_valid;
    issue_pkt_t issue_pkt;
    logic       exec_credit   = 1'b0;

    integer     seed;
    int         cycle         = 0;
    int         sent_cnt      = 0;
    int         credit_pulses = 0;
    int         issued_cnt    = 0;
    int         returned_cnt  = 0;
    int         send_cycle;
    logic       hold_credits  = 1'b0;   // set to starve execute credits
    word_t      next_pc;
    issue_pkt_t issued_q[$];
    int         issue_cycle_q[$];

    `include "decode_tasks.svh"

    decode_stage #(
        .QUEUE_DEPTH  (QUEUE_DEPTH),
        .EXEC_CREDITS (EXEC_CREDITS)
    ) decode_stage_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .fetch_valid_i  (fetch_valid),
        .fetch_pkt_i    (fetch_pkt),
        .fetch_credit_o (fetch_credit),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_rdata_i    (rs1_rdata),
        .rs2_rdata_i    (rs2_rdata),
        .issue_valid_o  (issue_valid),
        .issue_pkt_o    (issue_pkt),
        .exec_credit_i  (exec_credit)
    );

    // register file answers in the same cycle
    assign rs1_rdata = reg_val(rs1_addr);
    assign rs2_rdata = reg_val(rs2_addr);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // outputs sampled mid-cycle, away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (fetch_credit) begin
                credit_pulses++;
            end
            if (issue_valid) begin
                issued_q.push_back(issue_pkt);
                issue_cycle_q.push_back(cycle);
                issued_cnt++;
            end
        end
    end

    // execute side model, one returned slot per issued packet
    always @(posedge clk) begin
        #1;
        if (rst_n && !hold_credits && returned_cnt < issued_cnt) begin
            exec_credit = 1'b1;
            returned_cnt++;
        end else begin
            exec_credit = 1'b0;
        end
    end

    initial begin
        seed        = 52538;
        next_pc     = 32'h0000_1000;
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pkt   = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset();
        test_alu();
        test_mem();
        test_ctrl();
        test_backpressure();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter int QUEUE_DEPTH  = 4,
    parameter int EXEC_CREDITS = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   fetch_valid_i,
    input  decode_pkg::fetch_pkt_t fetch_pkt_i,
    output logic                   fetch_credit_o,
    output decode_pkg::reg_addr_t  rs1_addr_o,
    output decode_pkg::reg_addr_t  rs2_addr_o,
    input  decode_pkg::word_t      rs1_rdata_i,
    input  decode_pkg::word_t      rs2_rdata_i,
    output logic                   issue_valid_o,
    output decode_pkg::issue_pkt_t issue_pkt_o,
    input  logic                   exec_credit_i
);
    import decode_pkg::*;

    logic       head_valid;
    logic       head_pop;
    fetch_pkt_t head_pkt;
    issue_pkt_t decoded_pkt;

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) fetch_queue_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (fetch_valid_i),
        .push_pkt_i   (fetch_pkt_i),
        .pop_i        (head_pop),
        .head_valid_o (head_valid),
        .head_pkt_o   (head_pkt),
        .credit_o     (fetch_credit_o)
    );

    instr_decode instr_decode_i (
        .head_pkt_i  (head_pkt),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .issue_pkt_o (decoded_pkt)
    );

    issue_buffer #(
        .EXEC_CREDITS (EXEC_CREDITS)
    ) issue_buffer_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .head_valid_i  (head_valid),
        .decoded_pkt_i (decoded_pkt),
        .exec_credit_i (exec_credit_i),
        .pop_o         (head_pop),
        .issue_valid_o (issue_valid_o),
        .issue_pkt_o   (issue_pkt_o)
    );

endmodule

`default_nettype wire

// File: logic/issue_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module issue_buffer #(
    parameter int EXEC_CREDITS = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   head_valid_i,
    input  decode_pkg::issue_pkt_t decoded_pkt_i,
    input  logic                   exec_credit_i,
    output logic                   pop_o,
    output logic                   issue_valid_o,
    output decode_pkg::issue_pkt_t issue_pkt_o
);
    import decode_pkg::*;

    localparam int CNT_W = $clog2(EXEC_CREDITS + 1);

    logic [CNT_W-1:0] credit_q;
    logic             valid_q;
    issue_pkt_t       pkt_q;

    // take the head only when execute has room for it
    assign pop_o         = head_valid_i && (credit_q != '0);
    assign issue_valid_o = valid_q;
    assign issue_pkt_o   = pkt_q;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            credit_q <= CNT_W'(EXEC_CREDITS);
        end else begin
            case ({pop_o, exec_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: ;   // spend and return cancel out
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            pkt_q   <= '0;
        end else begin
            valid_q <= pop_o;   // one-cycle pulse per packet
            if (pop_o) begin
                pkt_q <= decoded_pkt_i;
            end
        end
    end

    // execute never returns more slots than it was given
    a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CNT_W'(EXEC_CREDITS))
        else $error("issue_buffer: credit count above EXEC_CREDITS");

endmodule

`default_nettype wire

// File: logic/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  decode_pkg::fetch_pkt_t head_pkt_i,
    input  decode_pkg::word_t      rs1_rdata_i,
    input  decode_pkg::word_t      rs2_rdata_i,
    output decode_pkg::reg_addr_t  rs1_addr_o,
    output decode_pkg::reg_addr_t  rs2_addr_o,
    output decode_pkg::issue_pkt_t issue_pkt_o
);
    import decode_pkg::*;

    word_t      instr;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    word_t      shamt;

    assign instr      = head_pkt_i.instr;
    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = instr[14:12];
    assign funct7     = instr[31:25];
    assign rs1_addr_o = instr[19:15];   // straight to the register file
    assign rs2_addr_o = instr[24:20];

    imm_gen imm_gen_i (
        .instr_i (instr),
        .imm_i_o (imm_i),
        .imm_s_o (imm_s),
        .imm_b_o (imm_b),
        .imm_j_o (imm_j),
        .imm_u_o (imm_u),
        .shamt_o (shamt)
    );

    always_comb begin
        issue_pkt_o          = '0;
        issue_pkt_o.alu_op   = ALU_NONE;
        issue_pkt_o.lsu_op   = LSU_NONE;
        issue_pkt_o.jump_op  = JUMP_NONE;
        issue_pkt_o.pc       = head_pkt_i.pc;
        issue_pkt_o.rd_addr  = instr[11:7];
        issue_pkt_o.rs1_data = rs1_rdata_i;
        issue_pkt_o.rs2_data = rs2_rdata_i;

        unique case (opcode)
            OPCODE_OP: begin
                issue_pkt_o.alu_a = rs1_rdata_i;
                issue_pkt_o.alu_b = rs2_rdata_i;
                unique case ({funct7, funct3})
                    {7'h00, 3'h0}: issue_pkt_o.alu_op = ALU_ADD;
                    {7'h20, 3'h0}: issue_pkt_o.alu_op = ALU_SUB;
                    {7'h00, 3'h4}: issue_pkt_o.alu_op = ALU_XOR;
                    {7'h00, 3'h6}: issue_pkt_o.alu_op = ALU_OR;
                    {7'h00, 3'h7}: issue_pkt_o.alu_op = ALU_AND;
                    {7'h00, 3'h1}: issue_pkt_o.alu_op = ALU_SLL;
                    {7'h00, 3'h5}: issue_pkt_o.alu_op = ALU_SRL;
                    {7'h20, 3'h5}: issue_pkt_o.alu_op = ALU_SRA;
                    {7'h00, 3'h2}: issue_pkt_o.alu_op = ALU_SLT;
                    {7'h00, 3'h3}: issue_pkt_o.alu_op = ALU_SLTU;
                    default: ;
                endcase
                // writes back only for a legal encoding
                issue_pkt_o.alu_sel = (issue_pkt_o.alu_op != ALU_NONE);
                issue_pkt_o.rd_we   = (issue_pkt_o.alu_op != ALU_NONE);
            end
            OPCODE_OP_IMM: begin
                issue_pkt_o.alu_a = rs1_rdata_i;
                issue_pkt_o.alu_b = imm_i;
                unique case (funct3)
                    3'h0: issue_pkt_o.alu_op = ALU_ADD;
                    3'h4: issue_pkt_o.alu_op = ALU_XOR;
                    3'h6: issue_pkt_o.alu_op = ALU_OR;
                    3'h7: issue_pkt_o.alu_op = ALU_AND;
                    3'h2: issue_pkt_o.alu_op = ALU_SLT;
                    3'h3: issue_pkt_o.alu_op = ALU_SLTU;
                    3'h1: begin
                        issue_pkt_o.alu_b = shamt;
                        if (funct7 == 7'h00) issue_pkt_o.alu_op = ALU_SLL;
                    end
                    3'h5: begin
                        issue_pkt_o.alu_b = shamt;
                        if (funct7 == 7'h00) issue_pkt_o.alu_op = ALU_SRL;
                        else if (funct7 == 7'h20) issue_pkt_o.alu_op = ALU_SRA;
                    end
                    default: ;
                endcase
                issue_pkt_o.alu_sel = (issue_pkt_o.alu_op != ALU_NONE);
                issue_pkt_o.rd_we   = (issue_pkt_o.alu_op != ALU_NONE);
            end
            OPCODE_LOAD: begin
                issue_pkt_o.alu_a   = rs1_rdata_i;   // address = rs1 + imm
                issue_pkt_o.alu_b   = imm_i;
                issue_pkt_o.lsu_req = 1'b1;
                issue_pkt_o.rd_we   = 1'b1;
                unique case (funct3)
                    3'h0:    issue_pkt_o.lsu_op = LSU_LB;
                    3'h1:    issue_pkt_o.lsu_op = LSU_LH;
                    3'h2:    issue_pkt_o.lsu_op = LSU_LW;
                    3'h4:    issue_pkt_o.lsu_op = LSU_LBU;
                    3'h5:    issue_pkt_o.lsu_op = LSU_LHU;
                    default: ;
                endcase
            end
            OPCODE_STORE: begin
                issue_pkt_o.alu_a   = rs1_rdata_i;
                issue_pkt_o.alu_b   = imm_s;
                issue_pkt_o.lsu_req = 1'b1;
                issue_pkt_o.lsu_we  = 1'b1;
                unique case (funct3)
                    3'h0:    issue_pkt_o.lsu_op = LSU_SB;
                    3'h1:    issue_pkt_o.lsu_op = LSU_SH;
                    3'h2:    issue_pkt_o.lsu_op = LSU_SW;
                    default: ;
                endcase
            end
            OPCODE_BRANCH: begin
                issue_pkt_o.alu_a     = head_pkt_i.pc;   // branch target
                issue_pkt_o.alu_b     = imm_b;
                issue_pkt_o.cond_jump = 1'b1;
                unique case (funct3)
                    3'h0:    issue_pkt_o.jump_op = JUMP_BEQ;
                    3'h1:    issue_pkt_o.jump_op = JUMP_BNE;
                    3'h4:    issue_pkt_o.jump_op = JUMP_BLT;
                    3'h5:    issue_pkt_o.jump_op = JUMP_BGE;
                    3'h6:    issue_pkt_o.jump_op = JUMP_BLTU;
                    3'h7:    issue_pkt_o.jump_op = JUMP_BGEU;
                    default: ;
                endcase
            end
            OPCODE_JAL: begin
                issue_pkt_o.alu_a    = head_pkt_i.pc;   // link address pc + 4
                issue_pkt_o.alu_b    = 32'd4;
                issue_pkt_o.alu_op   = ALU_ADD;
                issue_pkt_o.alu_sel  = 1'b1;
                issue_pkt_o.rd_we    = 1'b1;
                issue_pkt_o.jump_op  = JUMP_JAL;
                issue_pkt_o.jump_imm = imm_j;
            end
            OPCODE_JALR: begin
                if (funct3 == 3'h0) begin
                    issue_pkt_o.alu_a    = head_pkt_i.pc;
                    issue_pkt_o.alu_b    = 32'd4;
                    issue_pkt_o.alu_op   = ALU_ADD;
                    issue_pkt_o.alu_sel  = 1'b1;
                    issue_pkt_o.rd_we    = 1'b1;
                    issue_pkt_o.jump_op  = JUMP_JALR;
                    issue_pkt_o.jump_imm = imm_i;   // added to rs1_data downstream
                end
            end
            OPCODE_LUI: begin
                issue_pkt_o.alu_a   = '0;
                issue_pkt_o.alu_b   = imm_u;
                issue_pkt_o.alu_op  = ALU_ADD;
                issue_pkt_o.alu_sel = 1'b1;
                issue_pkt_o.rd_we   = 1'b1;
            end
            OPCODE_AUIPC: begin
                issue_pkt_o.alu_a   = head_pkt_i.pc;
                issue_pkt_o.alu_b   = imm_u;
                issue_pkt_o.alu_op  = ALU_ADD;
                issue_pkt_o.alu_sel = 1'b1;
                issue_pkt_o.rd_we   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  decode_pkg::word_t instr_i,
    output decode_pkg::word_t imm_i_o,
    output decode_pkg::word_t imm_s_o,
    output decode_pkg::word_t imm_b_o,
    output decode_pkg::word_t imm_j_o,
    output decode_pkg::word_t imm_u_o,
    output decode_pkg::word_t shamt_o
);

    // loads, op-imm, jalr
    assign imm_i_o = {{20{instr_i[31]}}, instr_i[31:20]};

    // stores
    assign imm_s_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    // branches, offset in halfwords
    assign imm_b_o = {
        {19{instr_i[31]}},
        instr_i[31],
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    // jal, 20-bit offset
    assign imm_j_o = {
        {11{instr_i[31]}},
        instr_i[31],
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    assign imm_u_o = {instr_i[31:12], 12'h000};   // lui, auipc

    assign shamt_o = {27'h0, instr_i[24:20]};      // unsigned shift amount

endmodule

`default_nettype wire

// File: logic/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   push_i,
    input  decode_pkg::fetch_pkt_t push_pkt_i,
    input  logic                   pop_i,
    output logic                   head_valid_o,
    output decode_pkg::fetch_pkt_t head_pkt_o,
    output logic                   credit_o
);
    import decode_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkt_t       mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             credit_q;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full         = (count_q == CNT_W'(QUEUE_DEPTH));
    assign wr_en        = push_i && !full;
    assign head_valid_o = (count_q != '0);
    assign rd_en        = pop_i && head_valid_o;
    assign head_pkt_o   = mem_q[rd_ptr_q];
    assign credit_o     = credit_q;

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= push_pkt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
            credit_q <= rd_en;  // slot freed, hand it back to fetch
        end
    end

    // fetch must hold a credit for every push
    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full)
        else $error("fetch_queue: push while full");

endmodule

`default_nettype wire

// File: logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

    typedef logic [31:0] word_t;      // data, address or instruction
    typedef logic [4:0]  reg_addr_t;

    // rv32i major opcodes kept by this stage
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NONE, LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU,
        LSU_SB, LSU_SH, LSU_SW
    } lsu_op_e;

    typedef enum logic [3:0] {
        JUMP_NONE, JUMP_BEQ, JUMP_BNE, JUMP_BLT, JUMP_BGE,
        JUMP_BLTU, JUMP_BGEU, JUMP_JAL, JUMP_JALR
    } jump_op_e;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    // packet handed to execute
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd_addr;
        logic      rd_we;
        logic      alu_sel;
        alu_op_e   alu_op;
        word_t     alu_a;
        word_t     alu_b;
        word_t     rs1_data;   // branch compare, jalr base
        word_t     rs2_data;   // branch compare, store data
        logic      lsu_req;
        logic      lsu_we;
        lsu_op_e   lsu_op;
        logic      cond_jump;
        jump_op_e  jump_op;
        word_t     jump_imm;
    } issue_pkt_t;

endpackage

`default_nettype wire
